// File: include/opf_defines.svh
`ifndef OPF_DEFINES_SVH
`define OPF_DEFINES_SVH

// --------------------
// Channels
// --------------------
`define OPF_N_CHAN          8
`define OPF_W_CHAN          3

// --------------------
// Datapath widths
// --------------------
`define OPF_W_DIN           18
`define OPF_W_MULT          8
`define OPF_W_RS            5
`define OPF_W_DOUT          32
// Correction times gain, full precision
`define OPF_W_DMULT         26

// AXI4-Lite bus widths
`define OPF_W_AXI_ADDR      8
`define OPF_W_AXI_DATA      32

// --------------------
// Register map
// --------------------
`define OPF_W_REG           3
`define OPF_REG_MIN         3'd0
`define OPF_REG_MAX         3'd1
`define OPF_REG_INIT        3'd2
`define OPF_REG_GAIN        3'd3
`define OPF_REG_CTRL        3'd4

// Byte address fields, index in 4:2 and channel in 7:5
`define OPF_ADDR_REG_LSB    2
`define OPF_ADDR_CHAN_LSB   5

// CTRL word bits
`define OPF_CTRL_CLR        0
`define OPF_CTRL_INJ        1

`endif

// File: rtl/opf_pkg.sv
`default_nettype none

`include "opf_defines.svh"

package opf_pkg;

    // --------------------
    // Stream types
    // --------------------

    // One correction from the controller
    typedef struct packed {
        logic                           valid;
        logic [`OPF_W_CHAN-1:0]         chan;
        logic signed [`OPF_W_DIN-1:0]   data;
    } opf_sample_t;

    // One bounded output word
    typedef struct packed {
        logic                           valid;
        logic [`OPF_W_CHAN-1:0]         chan;
        logic signed [`OPF_W_DOUT-1:0]  data;
    } opf_out_t;

    // --------------------
    // Configuration types
    // --------------------

    // Gain word, add_chan MSB set means no route
    typedef struct packed {
        logic [`OPF_W_AXI_DATA-`OPF_W_CHAN-1-`OPF_W_RS-`OPF_W_MULT-1:0] rsvd;
        logic [`OPF_W_CHAN:0]           add_chan;
        logic [`OPF_W_RS-1:0]           rs;
        logic signed [`OPF_W_MULT-1:0]  mult;
    } opf_gain_t;

    // Bus word, view picked by register index
    typedef union packed {
        logic signed [`OPF_W_DOUT-1:0]  value;
        opf_gain_t                      gain;
    } opf_wdata_u;

    // Single-cycle write strobe from the bus slave
    typedef struct packed {
        logic                           wr;
        logic [`OPF_W_CHAN-1:0]         chan;
        logic [`OPF_W_REG-1:0]          idx;
        opf_wdata_u                     data;
    } opf_cfg_wr_t;

    // Per-channel settings seen by the pipeline
    typedef struct packed {
        opf_gain_t                      gain;
        logic signed [`OPF_W_DOUT-1:0]  min;
        logic signed [`OPF_W_DOUT-1:0]  max;
        logic signed [`OPF_W_DOUT-1:0]  init;
    } opf_cfg_t;

    // Clear and inject requests, one bit per channel
    typedef struct packed {
        logic [`OPF_N_CHAN-1:0]         clr;
        logic [`OPF_N_CHAN-1:0]         inj;
    } opf_req_t;

endpackage

`default_nettype wire

// File: rtl/opf_axil_slave.sv
`default_nettype none

`include "opf_defines.svh"

module opf_axil_slave (
    input  wire logic                         clk_in,
    input  wire logic                         rst,
    // Write address and data
    input  wire logic [`OPF_W_AXI_ADDR-1:0]   awaddr,
    input  wire logic                         awvalid,
    output logic                              awready,
    input  wire logic [`OPF_W_AXI_DATA-1:0]   wdata,
    input  wire logic                         wvalid,
    output logic                              wready,
    // Write response
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  wire logic                         bready,
    // Read address and data
    input  wire logic [`OPF_W_AXI_ADDR-1:0]   araddr,
    input  wire logic                         arvalid,
    output logic                              arready,
    output logic [`OPF_W_AXI_DATA-1:0]        rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  wire logic                         rready,
    // Register file side
    output opf_pkg::opf_cfg_wr_t              cfg_wr,
    output logic [`OPF_W_CHAN-1:0]            rd_chan,
    output logic [`OPF_W_REG-1:0]             rd_reg,
    input  wire logic [`OPF_W_AXI_DATA-1:0]   rd_data
);
    import opf_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRESP,
        ST_RADDR,
        ST_RDATA
    } state_t;

    state_t state;
    logic   wr_go;

    // --------------------
    // Handshakes
    // --------------------

    // Both write channels together, writes win over reads
    assign wr_go   = (state == ST_IDLE) && awvalid && wvalid;
    assign awready = wr_go;
    assign wready  = wr_go;
    assign bvalid  = (state == ST_WRESP);
    assign arready = (state == ST_RADDR);
    assign rvalid  = (state == ST_RDATA);

    // Never an error response
    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    // Read select straight off the held address
    assign rd_chan = araddr[`OPF_ADDR_CHAN_LSB +: `OPF_W_CHAN];
    assign rd_reg  = araddr[`OPF_ADDR_REG_LSB +: `OPF_W_REG];

    // Write strobe in the handshake cycle
    always_comb begin
        cfg_wr.wr   = wr_go;
        cfg_wr.chan = awaddr[`OPF_ADDR_CHAN_LSB +: `OPF_W_CHAN];
        cfg_wr.idx  = awaddr[`OPF_ADDR_REG_LSB +: `OPF_W_REG];
        cfg_wr.data = opf_wdata_u'(wdata);
    end

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_go) begin
                        state <= ST_WRESP;
                    end else if (arvalid) begin
                        state <= ST_RADDR;
                    end
                end
                // Hold response until master takes it
                ST_WRESP: begin
                    if (bready) begin
                        state <= ST_IDLE;
                    end
                end
                // AR handshake here, data captured at the same edge
                ST_RADDR: begin
                    if (arvalid) begin
                        state <= ST_RDATA;
                    end
                end
                ST_RDATA: begin
                    if (rready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Registered read word
    always_ff @(posedge clk_in) begin
        if (state == ST_RADDR) begin
            rdata <= rd_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/opf_cfg_regs.sv
`default_nettype none

`include "opf_defines.svh"

module opf_cfg_regs (
    input  wire logic                         clk_in,
    input  wire logic                         rst,
    input  wire opf_pkg::opf_cfg_wr_t         cfg_wr,
    input  wire logic [`OPF_W_CHAN-1:0]       rd_chan,
    input  wire logic [`OPF_W_REG-1:0]        rd_reg,
    input  wire logic [`OPF_N_CHAN-1:0]       inj_ack,
    output opf_pkg::opf_cfg_t                 cfg [`OPF_N_CHAN],
    output opf_pkg::opf_req_t                 req,
    output logic [`OPF_W_AXI_DATA-1:0]        rd_data
);
    import opf_pkg::*;

    // Route field with only the MSB set
    localparam logic [`OPF_W_CHAN:0] ROUTE_NONE = {1'b1, {`OPF_W_CHAN{1'b0}}};

    logic wr_ctrl;

    assign wr_ctrl = cfg_wr.wr && (cfg_wr.idx == `OPF_REG_CTRL);

    // --------------------
    // Channel settings
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < `OPF_N_CHAN; i++) begin
                cfg[i]               <= '0;
                cfg[i].gain.add_chan <= ROUTE_NONE;
            end
        end else if (cfg_wr.wr) begin
            // Bounds and init use the signed view, GAIN the field view
            case (cfg_wr.idx)
                `OPF_REG_MIN:  cfg[cfg_wr.chan].min  <= cfg_wr.data.value;
                `OPF_REG_MAX:  cfg[cfg_wr.chan].max  <= cfg_wr.data.value;
                `OPF_REG_INIT: cfg[cfg_wr.chan].init <= cfg_wr.data.value;
                `OPF_REG_GAIN: cfg[cfg_wr.chan].gain <= cfg_wr.data.gain;
                default: begin
                end
            endcase
        end
    end

    // --------------------
    // Requests
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rst) begin
            req <= '0;
        end else begin
            // Clear lasts a single cycle
            req.clr <= '0;
            // Inject held until pipeline picks it
            req.inj <= req.inj & ~inj_ack;
            if (wr_ctrl) begin
                req.clr[cfg_wr.chan] <= cfg_wr.data.value[`OPF_CTRL_CLR];
                // new request wins over a same-cycle ack
                if (cfg_wr.data.value[`OPF_CTRL_INJ]) begin
                    req.inj[cfg_wr.chan] <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // Read-back
    // --------------------
    always_comb begin
        rd_data = '0;
        case (rd_reg)
            `OPF_REG_MIN:  rd_data = cfg[rd_chan].min;
            `OPF_REG_MAX:  rd_data = cfg[rd_chan].max;
            `OPF_REG_INIT: rd_data = cfg[rd_chan].init;
            `OPF_REG_GAIN: rd_data = cfg[rd_chan].gain;
            // Only pending inject visible
            `OPF_REG_CTRL: rd_data[`OPF_CTRL_INJ] = req.inj[rd_chan];
            default:       rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/opf_pipe.sv
`default_nettype none

`include "opf_defines.svh"

module opf_pipe (
    input  wire logic                         clk_in,
    input  wire logic                         rst,
    input  wire opf_pkg::opf_sample_t         sample_in,
    input  wire opf_pkg::opf_cfg_t            cfg [`OPF_N_CHAN],
    input  wire opf_pkg::opf_req_t            req,
    output logic [`OPF_N_CHAN-1:0]            inj_ack,
    output opf_pkg::opf_out_t                 result
);
    import opf_pkg::*;

    localparam int W_CHAN  = `OPF_W_CHAN;
    localparam int W_DMULT = `OPF_W_DMULT;
    // Scaled plus routed term
    localparam int W_SUM_A = W_DMULT + 1;
    // Plus previous output, one guard bit for the clamp
    localparam int W_SUM_B = ((W_SUM_A > `OPF_W_DOUT) ? W_SUM_A : `OPF_W_DOUT) + 1;

    // Per-stage control tag
    typedef struct packed {
        logic                 valid;
        logic                 inj;
        logic [W_CHAN-1:0]    chan;
    } tag_t;

    tag_t                           pick;
    tag_t                           tag_p [1:4];
    logic                           valid_p5;
    logic [W_CHAN-1:0]              chan_p5;

    logic signed [`OPF_W_DIN-1:0]   din_p1;
    logic signed [W_DMULT-1:0]      prod_p1;
    logic [W_CHAN:0]                route_p1;
    logic signed [W_DMULT-1:0]      dmult_p2;
    logic signed [W_DMULT-1:0]      add_p2;
    logic signed [W_SUM_A-1:0]      dsum_a_p3;
    logic signed [`OPF_W_DOUT-1:0]  dprev_p3;
    logic signed [W_SUM_B-1:0]      dsum_b_p4;
    logic signed [`OPF_W_DOUT-1:0]  min_p4;
    logic signed [`OPF_W_DOUT-1:0]  max_p4;
    logic signed [`OPF_W_DOUT-1:0]  init_p4;
    logic signed [W_SUM_B-1:0]      dsel_p4;
    logic signed [`OPF_W_DOUT-1:0]  dclamp_p4;
    logic signed [`OPF_W_DOUT-1:0]  dout_p5;

    // History, previous output and last scaled value per channel
    logic signed [`OPF_W_DOUT-1:0]  dout_mem [`OPF_N_CHAN];
    logic signed [W_DMULT-1:0]      dmult_mem [`OPF_N_CHAN];

    // --------------------
    // Stage 1 pick
    // --------------------
    always_comb begin
        pick    = '0;
        inj_ack = '0;
        if (sample_in.valid) begin
            pick.valid = 1'b1;
            pick.chan  = sample_in.chan;
        end else begin
            // Downward scan, lowest pending channel ends up chosen
            for (int i = `OPF_N_CHAN - 1; i >= 0; i--) begin
                if (req.inj[i]) begin
                    pick.valid = 1'b1;
                    pick.inj   = 1'b1;
                    pick.chan  = W_CHAN'(i);
                end
            end
            // No ack if a clear drops it, retried next cycle
            if (pick.valid && !req.clr[pick.chan]) begin
                inj_ack[pick.chan] = 1'b1;
            end
        end
    end

    // --------------------
    // Control tags and flush
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int s = 1; s <= 4; s++) begin
                tag_p[s] <= '0;
            end
            valid_p5 <= 1'b0;
            chan_p5  <= '0;
        end else begin
            tag_p[1]       <= pick;
            tag_p[1].valid <= pick.valid && !req.clr[pick.chan];
            // A clear kills every stage holding its channel
            for (int s = 2; s <= 4; s++) begin
                tag_p[s]       <= tag_p[s-1];
                tag_p[s].valid <= tag_p[s-1].valid && !req.clr[tag_p[s-1].chan];
            end
            valid_p5 <= tag_p[4].valid && !req.clr[tag_p[4].chan];
            chan_p5  <= tag_p[4].chan;
        end
    end

    // Signed product, fits in W_DMULT
    assign prod_p1  = W_DMULT'($signed(din_p1)) *
                      W_DMULT'($signed(cfg[tag_p[1].chan].gain.mult));
    assign route_p1 = cfg[tag_p[1].chan].gain.add_chan;

    // --------------------
    // Datapath
    // --------------------
    always_ff @(posedge clk_in) begin
        // Stage 1, injects carry zero data
        din_p1 <= sample_in.valid ? sample_in.data : '0;

        // Stage 2 scale and routed fetch
        dmult_p2 <= prod_p1 >>> cfg[tag_p[1].chan].gain.rs;
        add_p2   <= route_p1[W_CHAN] ? '0 : dmult_mem[route_p1[W_CHAN-1:0]];

        // Stage 3 routed sum, previous output fetch
        dsum_a_p3 <= W_SUM_A'(dmult_p2) + W_SUM_A'(add_p2);
        dprev_p3  <= dout_mem[tag_p[2].chan];

        // Stage 4 accumulate, bounds fetch
        dsum_b_p4 <= W_SUM_B'(dsum_a_p3) + W_SUM_B'(dprev_p3);
        min_p4    <= cfg[tag_p[3].chan].min;
        max_p4    <= cfg[tag_p[3].chan].max;
        init_p4   <= cfg[tag_p[3].chan].init;

        // Stage 5 output word
        dout_p5 <= dclamp_p4;
    end

    // Init replaces the sum for injects, then clamp
    always_comb begin
        dsel_p4 = tag_p[4].inj ? W_SUM_B'(init_p4) : dsum_b_p4;
        if (dsel_p4 > W_SUM_B'(max_p4)) begin
            dclamp_p4 = max_p4;
        end else if (dsel_p4 < W_SUM_B'(min_p4)) begin
            dclamp_p4 = min_p4;
        end else begin
            dclamp_p4 = dsel_p4[`OPF_W_DOUT-1:0];
        end
    end

    // --------------------
    // History write-back
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < `OPF_N_CHAN; i++) begin
                dout_mem[i]  <= '0;
                dmult_mem[i] <= '0;
            end
        end else begin
            // Scaled value from real samples only
            if (tag_p[2].valid && !tag_p[2].inj) begin
                dmult_mem[tag_p[2].chan] <= dmult_p2;
            end
            if (tag_p[4].valid) begin
                dout_mem[tag_p[4].chan] <= dclamp_p4;
            end
            // Clear overrides any write-back above
            for (int i = 0; i < `OPF_N_CHAN; i++) begin
                if (req.clr[i]) begin
                    dout_mem[i]  <= cfg[i].init;
                    dmult_mem[i] <= '0;
                end
            end
        end
    end

    always_comb begin
        result.valid = valid_p5;
        result.chan  = chan_p5;
        result.data  = dout_p5;
    end

endmodule

`default_nettype wire

// File: rtl/opf_top.sv
`default_nettype none

`include "opf_defines.svh"

module opf_top (
    input  wire logic                         clk_in,
    input  wire logic                         rst,
    // AXI4-Lite slave port
    input  wire logic [`OPF_W_AXI_ADDR-1:0]   awaddr,
    input  wire logic                         awvalid,
    output logic                              awready,
    input  wire logic [`OPF_W_AXI_DATA-1:0]   wdata,
    input  wire logic                         wvalid,
    output logic                              wready,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  wire logic                         bready,
    input  wire logic [`OPF_W_AXI_ADDR-1:0]   araddr,
    input  wire logic                         arvalid,
    output logic                              arready,
    output logic [`OPF_W_AXI_DATA-1:0]        rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  wire logic                         rready,
    // Sample stream in, filtered words out
    input  wire opf_pkg::opf_sample_t         sample_in,
    output opf_pkg::opf_out_t                 result
);
    import opf_pkg::*;

    opf_cfg_wr_t                    cfg_wr;
    logic [`OPF_W_CHAN-1:0]         rd_chan;
    logic [`OPF_W_REG-1:0]          rd_reg;
    logic [`OPF_W_AXI_DATA-1:0]     rd_data;
    opf_cfg_t                       cfg [`OPF_N_CHAN];
    opf_req_t                       req;
    logic [`OPF_N_CHAN-1:0]         inj_ack;

    // --------------------
    // Bus slave
    // --------------------
    opf_axil_slave u_axil (
        .clk_in  (clk_in),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cfg_wr  (cfg_wr),
        .rd_chan (rd_chan),
        .rd_reg  (rd_reg),
        .rd_data (rd_data)
    );

    // Settings and request bits
    opf_cfg_regs u_regs (
        .clk_in  (clk_in),
        .rst     (rst),
        .cfg_wr  (cfg_wr),
        .rd_chan (rd_chan),
        .rd_reg  (rd_reg),
        .inj_ack (inj_ack),
        .cfg     (cfg),
        .req     (req),
        .rd_data (rd_data)
    );

    // --------------------
    // Filter datapath
    // --------------------
    opf_pipe u_pipe (
        .clk_in    (clk_in),
        .rst       (rst),
        .sample_in (sample_in),
        .cfg       (cfg),
        .req       (req),
        .inj_ack   (inj_ack),
        .result    (result)
    );

endmodule

`default_nettype wire

// File: verif/opf_assert.sv
`default_nettype none

`include "opf_defines.svh"

module opf_assert (
    input wire logic                      clk_in,
    input wire logic                      rst,
    input wire logic                      awvalid,
    input wire logic                      awready,
    input wire logic                      arvalid,
    input wire logic                      arready,
    input wire logic                      bvalid,
    input wire logic                      bready,
    input wire logic                      rvalid,
    input wire logic                      rready,
    input wire logic [`OPF_N_CHAN-1:0]    inj_ack,
    input wire opf_pkg::opf_sample_t      sample_in,
    input wire opf_pkg::opf_out_t         result
);

    int n_fail;

    // --------------------
    // AXI valid held until ready
    // --------------------
    aw_hold: assert property (@(posedge clk_in) disable iff (rst)
        (awvalid && !awready) |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            n_fail++;
        end

    ar_hold: assert property (@(posedge clk_in) disable iff (rst)
        (arvalid && !arready) |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            n_fail++;
        end

    // Slave side responses
    b_hold: assert property (@(posedge clk_in) disable iff (rst)
        (bvalid && !bready) |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            n_fail++;
        end

    r_hold: assert property (@(posedge clk_in) disable iff (rst)
        (rvalid && !rready) |=> rvalid)
        else begin
            $error("rvalid dropped before rready");
            n_fail++;
        end

    // --------------------
    // Pipeline timing
    // --------------------

    // Each output traces back to a sample or inject five cycles earlier
    out_origin: assert property (@(posedge clk_in) disable iff (rst)
        result.valid |-> $past(sample_in.valid || (|inj_ack), 5))
        else begin
            $error("result valid without a sample or inject five cycles before");
            n_fail++;
        end

    // Same channel at least five cycles apart
    chan_spacing: assert property (@(posedge clk_in) disable iff (rst)
        sample_in.valid |->
            !($past(sample_in.valid, 1) && $past(sample_in.chan, 1) == sample_in.chan) &&
            !($past(sample_in.valid, 2) && $past(sample_in.chan, 2) == sample_in.chan) &&
            !($past(sample_in.valid, 3) && $past(sample_in.chan, 3) == sample_in.chan) &&
            !($past(sample_in.valid, 4) && $past(sample_in.chan, 4) == sample_in.chan))
        else begin
            $error("two samples for one channel closer than five cycles");
            n_fail++;
        end

endmodule

`default_nettype wire

// File: verif/opf_tb.sv
`default_nettype none

`include "opf_defines.svh"

module opf_tb;
    import opf_pkg::*;

    localparam string DATA_FILE       = "verif/opf_testdata.txt";
    localparam int    CYCLES_PER_LINE = 40;
    localparam int    INJECT_WAIT     = 12;

    logic                          clk_in;
    logic                          rst;
    logic [`OPF_W_AXI_ADDR-1:0]    awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [`OPF_W_AXI_DATA-1:0]    wdata;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [`OPF_W_AXI_ADDR-1:0]    araddr;
    logic                          arvalid;
    logic                          arready;
    logic [`OPF_W_AXI_DATA-1:0]    rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;
    opf_sample_t                   sample_in;
    opf_out_t                      result;

    int n_lines;
    int n_test;
    int n_check;
    int n_err;

    opf_top dut (.*);

    bind opf_top opf_assert u_assert (.*);

    // --------------------
    // Clock and watchdog
    // --------------------
    initial begin
        clk_in = 1'b0;
        forever begin
            #2 clk_in = ~clk_in;
        end
    end

    // Budget scales with the number of data lines
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * CYCLES_PER_LINE) @(posedge clk_in);
        $display("timeout after %0d cycles, run never reached its end",
                 n_lines * CYCLES_PER_LINE);
        $display("sim failed");
        $finish;
    end

    // Drive phase, one unit past the edge
    task automatic tick();
        @(posedge clk_in);
        #1;
    endtask

    function automatic logic [`OPF_W_AXI_ADDR-1:0] ctrl_addr(
        input logic [`OPF_W_CHAN-1:0] chan
    );
        return {chan, `OPF_REG_CTRL, 2'b00};
    endfunction

    // Field count of one data line
    task automatic expect_fields(input int got, input int want, input logic [7:0] cmd);
        if (got != want) begin
            n_err++;
            $display("line for command %c has %0d fields, expected %0d", cmd, got, want);
        end
    endtask

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_out(input opf_out_t got, input opf_out_t exp_o);
        n_check++;
        if (got !== exp_o) begin
            n_err++;
            $display("ERROR @ %0t: result v=%0b ch=%0d data=%h, expected v=%0b ch=%0d data=%h",
                     $time, got.valid, got.chan, got.data,
                     exp_o.valid, exp_o.chan, exp_o.data);
        end
    endtask

    task automatic check_rd(input logic [`OPF_W_AXI_DATA-1:0] got,
                            input logic [`OPF_W_AXI_DATA-1:0] exp_d);
        n_check++;
        if (got !== exp_d) begin
            n_err++;
            $display("ERROR @ %0t: read data %h, expected %h", $time, got, exp_d);
        end
    endtask

    // AXI response code, OKAY is 2'b00
    task automatic check_resp(input logic [1:0] got);
        n_check++;
        if (got !== 2'b00) begin
            n_err++;
            $display("ERROR @ %0t: response %b, expected OKAY", $time, got);
        end
    endtask

    // --------------------
    // AXI4-Lite master
    // --------------------
    task automatic write_reg(input logic [`OPF_W_AXI_ADDR-1:0] addr,
                             input logic [`OPF_W_AXI_DATA-1:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // Ready is combinational, look mid-cycle
        #1;
        while (!(awready && wready)) begin
            @(posedge clk_in);
            #2;
        end
        tick();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) begin
            tick();
        end
        check_resp(bresp);
        // bready stays high, response taken here
        tick();
    endtask

    task automatic read_reg(input logic [`OPF_W_AXI_ADDR-1:0] addr,
                            output logic [`OPF_W_AXI_DATA-1:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        tick();
        while (!arready) begin
            tick();
        end
        // AR beat on this edge
        tick();
        arvalid = 1'b0;
        while (!rvalid) begin
            tick();
        end
        data = rdata;
        check_resp(rresp);
        tick();
    endtask

    // --------------------
    // Stream side
    // --------------------
    task automatic drive_sample(input logic [`OPF_W_CHAN-1:0] chan,
                                input logic signed [`OPF_W_DIN-1:0] data,
                                input logic signed [`OPF_W_DOUT-1:0] exp_data);
        opf_out_t exp_o;
        exp_o.valid     = 1'b1;
        exp_o.chan      = chan;
        exp_o.data      = exp_data;
        sample_in.valid = 1'b1;
        sample_in.chan  = chan;
        sample_in.data  = data;
        tick();
        sample_in.valid = 1'b0;
        // Five edges from the sample edge
        repeat (4) tick();
        check_out(result, exp_o);
        // Next sample six cycles after this one
        tick();
    endtask

    task automatic await_inject(input logic [`OPF_W_CHAN-1:0] chan,
                                input logic signed [`OPF_W_DOUT-1:0] exp_data);
        opf_out_t exp_o;
        int       waited;
        exp_o.valid = 1'b1;
        exp_o.chan  = chan;
        exp_o.data  = exp_data;
        waited      = 0;
        write_reg(ctrl_addr(chan), 32'h2);
        while (!result.valid && waited < INJECT_WAIT) begin
            tick();
            waited++;
        end
        if (result.valid) begin
            check_out(result, exp_o);
            tick();
        end else begin
            n_err++;
            $display("inject on channel %0d never produced an output", chan);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int                           fd;
        int                           n_fld;
        int                           err_before;
        logic [7:0]                   cmd;
        logic [31:0]                  f1;
        logic [31:0]                  f2;
        logic [31:0]                  f3;
        logic [`OPF_W_AXI_DATA-1:0]   rd;
        string                        line;

        rst       = 1'b1;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        sample_in = '0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", DATA_FILE);
            $display("sim failed");
            $finish;
        end else begin
            // First pass only counts data lines for the watchdog
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n_lines++;
                end
            end
            $fclose(fd);
            fd = $fopen(DATA_FILE, "r");

            repeat (16) @(posedge clk_in);
            #1;
            rst = 1'b0;
            tick();

            while ($fscanf(fd, " %c", cmd) == 1) begin
                if (cmd == "#") begin
                    n_fld = $fgets(line, fd);
                end else begin
                    n_test++;
                    err_before = n_err;
                    case (cmd)
                        "W": begin
                            n_fld = $fscanf(fd, "%h %h", f1, f2);
                            expect_fields(n_fld, 2, cmd);
                            write_reg(f1[`OPF_W_AXI_ADDR-1:0], f2);
                        end
                        "R": begin
                            n_fld = $fscanf(fd, "%h %h", f1, f2);
                            expect_fields(n_fld, 2, cmd);
                            read_reg(f1[`OPF_W_AXI_ADDR-1:0], rd);
                            check_rd(rd, f2);
                        end
                        "S": begin
                            n_fld = $fscanf(fd, "%h %h %h", f1, f2, f3);
                            expect_fields(n_fld, 3, cmd);
                            drive_sample(f1[`OPF_W_CHAN-1:0], f2[`OPF_W_DIN-1:0], f3);
                        end
                        "I": begin
                            n_fld = $fscanf(fd, "%h %h", f1, f2);
                            expect_fields(n_fld, 2, cmd);
                            await_inject(f1[`OPF_W_CHAN-1:0], f2);
                        end
                        // Clear is a CTRL write with bit 0
                        "C": begin
                            n_fld = $fscanf(fd, "%h", f1);
                            expect_fields(n_fld, 1, cmd);
                            write_reg(ctrl_addr(f1[`OPF_W_CHAN-1:0]), 32'h1);
                        end
                        default: begin
                            n_err++;
                            $display("unknown command '%c' in %s", cmd, DATA_FILE);
                        end
                    endcase
                    $display("test %0d (%c): %s", n_test, cmd,
                             (n_err == err_before) ? "ok" : "mismatch");
                end
            end
            $fclose(fd);

            $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                     n_test, n_check, n_err, dut.u_assert.n_fail);
            if (n_err == 0 && dut.u_assert.n_fail == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verif/opf_testdata.txt
# W addr data | R addr expected | S chan data expected | I chan expected | C chan
# all fields hex, sample data 18-bit two's complement, outputs 32-bit
W 00 fff00000
W 04 00100000
W 08 00000064
W 0c 00010204
R 00 fff00000
R 04 00100000
R 08 00000064
R 0c 00010204
C 0
S 0 00010 00000074
S 0 3fff6 0000006a
S 0 3ff00 ffffff6a
R 10 00000000
W 20 ffffffce
W 24 000000c8
W 2c 00010008
S 1 00014 000000a0
S 1 00014 000000c8
S 1 3fffb 000000a0
S 1 3ffe2 ffffffce
W 40 fff00000
W 44 00100000
W 4c 00010204
W 60 fff00000
W 64 00100000
W 6c 00004102
S 2 00032 00000032
S 3 00007 00000039
R 6c 00004102
C 2
S 3 00007 00000040
W 80 00000000
W 84 00000190
W 88 000001f4
W 8c 00010204
I 4 00000190
R 90 00000000
W 84 000003e8
C 4
S 4 0000a 000001fe

// File: vlog.f
+incdir+include
rtl/opf_pkg.sv
rtl/opf_axil_slave.sv
rtl/opf_cfg_regs.sv
rtl/opf_pipe.sv
rtl/opf_top.sv
verif/opf_assert.sv
verif/opf_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= opf_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= sim passed

.PHONY: sim clean

# Build and run, pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
